// File: Makefile
SOURCES := $(filter-out +incdir+%,$(shell cat compile.f)) include/boa_settings.svh

obj_dir/Vtb_mdu: compile.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tb_mdu -f compile.f

run: obj_dir/Vtb_mdu
	@out="$$(./obj_dir/Vtb_mdu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: compile.f
+incdir+include
logic/boa_isa_pkg.sv
logic/boa_mdu_pkg.sv
logic/boa_mul_pipe.sv
logic/boa_div_iter.sv
logic/boa_mdu_ctrl.sv
logic/boa_mdu.sv
dv/tb_clock.sv
dv/mdu_checker.sv
dv/tb_mdu.sv

// File: dv/mdu_checker.sv
// Result checker for the multiply/divide/shift unit.
// Queues accepted requests, predicts each result with a reference model
// and compares it against every response in acceptance order.

module mdu_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  boa_mdu_pkg::mdu_req_t req,
    input  logic                  req_valid,
    input  logic                  req_ready,
    input  boa_mdu_pkg::mdu_rsp_t rsp,
    input  logic                  rsp_valid,
    input  logic                  rsp_ready,
    output int                    accepted,
    output int                    checks,
    output int                    errors,
    output int                    pending
);

    timeunit 1ns;
    timeprecision 1ps;

    // Requests still waiting for their response, oldest first.
    boa_mdu_pkg::mdu_req_t exp_q [$];
    // Reset level seen at the previous edge.
    logic                  reset_q;

    // Reference model from 64-bit arithmetic and the RV32M rules.
    function automatic boa_isa_pkg::word_t model_result(boa_mdu_pkg::mdu_req_t r);
        longint             a_s;
        longint             b_s;
        longint             a_u;
        longint             b_u;
        logic [63:0]        prod;
        int                 sa;
        int                 sb;
        logic               ovf;
        boa_isa_pkg::word_t res;
        a_s  = $signed(r.lhs);
        b_s  = $signed(r.rhs);
        a_u  = r.lhs;
        b_u  = r.rhs;
        sa   = r.lhs;
        sb   = r.rhs;
        // Most negative number over minus one.
        ovf  = r.lhs == 32'h8000_0000 && r.rhs == 32'hffff_ffff;
        prod = '0;
        case (r.op)
            boa_isa_pkg::MUL: begin
                prod = a_s * b_s;
                res  = prod[31:0];
            end
            boa_isa_pkg::MULH: begin
                prod = a_s * b_s;
                res  = prod[63:32];
            end
            boa_isa_pkg::MULHSU: begin
                prod = a_s * b_u;
                res  = prod[63:32];
            end
            boa_isa_pkg::MULHU: begin
                // Low 64 bits stay exact even past the signed range.
                prod = a_u * b_u;
                res  = prod[63:32];
            end
            boa_isa_pkg::DIV: begin
                if (r.rhs == '0) res = '1;
                else if (ovf) res = 32'h8000_0000;
                else res = sa / sb;
            end
            boa_isa_pkg::DIVU: res = (r.rhs == '0) ? '1 : r.lhs / r.rhs;
            boa_isa_pkg::REM: begin
                if (r.rhs == '0) res = r.lhs;
                else if (ovf) res = '0;
                else res = sa % sb;
            end
            boa_isa_pkg::REMU: res = (r.rhs == '0) ? r.lhs : r.lhs % r.rhs;
            // Shifts work on the 64-bit extended word.
            boa_isa_pkg::SLL: begin
                prod = a_u << r.rhs[4:0];
                res  = prod[31:0];
            end
            boa_isa_pkg::SRL: begin
                prod = a_u >> r.rhs[4:0];
                res  = prod[31:0];
            end
            boa_isa_pkg::SRA: begin
                prod = a_s >>> r.rhs[4:0];
                res  = prod[31:0];
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    initial begin
        accepted = 0;
        checks   = 0;
        errors   = 0;
        pending  = 0;
        reset_q  = 1'b0;
    end

    always @(posedge clk) begin
        boa_mdu_pkg::mdu_req_t head;
        boa_isa_pkg::word_t    exp;
        // No response during reset or in the first cycle after it.
        if (reset_q && rsp_valid !== 1'b0) begin
            $display("[ERROR] %0t rsp_valid: expected 0, got %b (reset or first cycle after it)",
                     $time, rsp_valid);
            errors++;
        end
        reset_q = reset;
        if (!reset) begin
            // Responses first. A request taken on this edge is not answered yet.
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("response for rd %0d arrived at %0t with no request outstanding",
                             rsp.rd, $time);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    exp  = model_result(head);
                    checks++;
                    if (rsp.rd !== head.rd) begin
                        $display("[ERROR] %0t rsp.rd: expected %0d, got %0d (%s)",
                                 $time, head.rd, rsp.rd, head.op.name());
                        errors++;
                    end
                    if (rsp.result !== exp) begin
                        $display("[ERROR] %0t rsp.result: expected %h, got %h (%s %h %h)",
                                 $time, exp, rsp.result, head.op.name(), head.lhs, head.rhs);
                        errors++;
                    end
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(req);
                accepted++;
            end
            pending = exp_q.size();
        end
    end

endmodule

// File: dv/tb_clock.sv
// Clock and reset generator for the testbench.
// Free-running clock and a synchronous reset held for a set number of cycles.

module tb_clock #(
    parameter int period       = 10,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge.
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: dv/tb_mdu.sv
// Testbench top for the multiply/divide/shift unit.
// Clock and reset, DUT, checker, seeded random requests in groups of
// tests with random back-pressure, and a cycle-count timeout.

`include "boa_settings.svh"

module tb_mdu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles   = 10;
    localparam int num_tests      = 8;
    localparam int reqs_per_test  = 250;
    // Worst divide latency plus margin for every request.
    localparam int timeout_cycles =
        num_tests * reqs_per_test * (`BOA_DIV_STEPS + 8) + reset_cycles;

    logic                  clk;
    logic                  reset;
    boa_mdu_pkg::mdu_req_t req;
    logic                  req_valid;
    logic                  req_ready;
    boa_mdu_pkg::mdu_rsp_t rsp;
    logic                  rsp_valid;
    logic                  rsp_ready;

    int accepted;
    int checks;
    int errors;
    int pending;
    int accepted_seen;
    int cycles;

    // Shape of the running test.
    string test_name;
    int    op_lo;
    int    op_hi;
    int    corner_pct;
    int    valid_pct;
    int    ready_pct;

    tb_clock #(
        .period       (10),
        .reset_cycles (reset_cycles)
    ) i_clock (
        .clk   (clk),
        .reset (reset)
    );

    boa_mdu i_dut (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    mdu_checker i_checker (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .accepted  (accepted),
        .checks    (checks),
        .errors    (errors),
        .pending   (pending)
    );

    // Op range, operand mix and handshake rates per test.
    task automatic configure_test(input int idx);
        op_lo      = 0;
        op_hi      = 10;
        corner_pct = 10;
        valid_pct  = 70;
        ready_pct  = 70;
        case (idx)
            0: test_name = "mixed ops, random operands";
            1: begin
                test_name  = "multiplies back to back, corner operands";
                op_hi      = 3;
                corner_pct = 50;
                valid_pct  = 100;
                ready_pct  = 100;
            end
            2: begin
                test_name  = "divides and remainders";
                op_lo      = 4;
                op_hi      = 7;
                corner_pct = 40;
            end
            3: begin
                // Every operand a corner value, so zero divisors and overflow recur.
                test_name  = "divide corner cases";
                op_lo      = 4;
                op_hi      = 7;
                corner_pct = 100;
            end
            4: begin
                test_name  = "shifts with full-width amounts";
                op_lo      = 8;
                op_hi      = 10;
                corner_pct = 30;
            end
            5: begin
                test_name = "mixed ops, heavy response stalls";
                ready_pct = 25;
            end
            6: begin
                test_name = "multiply bursts with stalls";
                op_hi     = 3;
                valid_pct = 100;
                ready_pct = 50;
            end
            default: begin
                test_name  = "mixed ops, corner operands";
                corner_pct = 60;
            end
        endcase
    endtask

    // Corner value or a random word.
    function automatic boa_isa_pkg::word_t pick_operand();
        boa_isa_pkg::word_t corners [5] = '{32'h0, 32'h1, 32'hffff_ffff,
                                            32'h8000_0000, 32'h7fff_ffff};
        if ($urandom_range(99) < corner_pct) begin
            return corners[$urandom_range(4)];
        end
        return $urandom();
    endfunction

    function automatic boa_mdu_pkg::mdu_req_t next_request();
        boa_mdu_pkg::mdu_req_t r;
        r.op  = boa_isa_pkg::mdu_op_e'(4'($urandom_range(op_hi, op_lo)));
        r.lhs = pick_operand();
        r.rhs = pick_operand();
        r.rd  = 5'($urandom_range(31));
        return r;
    endfunction

    // Sends one group of requests and waits for all of their responses.
    task automatic run_test(input int idx);
        int sent;
        int err_before;
        int chk_before;
        sent       = 0;
        err_before = errors;
        chk_before = checks;
        configure_test(idx);
        while (sent < reqs_per_test) begin
            @(negedge clk);
            // Checker count moves on the edge that took the request.
            if (req_valid && accepted != accepted_seen) begin
                accepted_seen = accepted;
                sent++;
                req_valid     = 1'b0;
            end
            rsp_ready = $urandom_range(99) < ready_pct;
            if (!req_valid && sent < reqs_per_test && $urandom_range(99) < valid_pct) begin
                req       = next_request();
                req_valid = 1'b1;
            end
        end
        while (pending != 0) begin
            @(negedge clk);
            rsp_ready = $urandom_range(99) < ready_pct;
        end
        // A few open cycles expose any extra response.
        rsp_ready = 1'b1;
        repeat (4) @(negedge clk);
        $display("test %0d (%s): %0d responses, %0d errors",
                 idx, test_name, checks - chk_before, errors - err_before);
    endtask

    initial begin
        void'($urandom(56));
        req           = '0;
        req_valid     = 1'b0;
        rsp_ready     = 1'b0;
        accepted_seen = 0;
        @(negedge clk);
        while (reset) @(negedge clk);
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        if (checks != num_tests * reqs_per_test) begin
            $display("expected %0d responses but checked %0d",
                     num_tests * reqs_per_test, checks);
        end
        $display("%0d tests, %0d requests accepted, %0d responses checked, %0d errors",
                 num_tests, accepted, checks, errors);
        if (errors == 0 && checks == num_tests * reqs_per_test) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Run limit in clock cycles.
    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d requests still waiting for a response",
                 cycles, pending);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: include/boa_settings.svh
// Build-time settings of the multiply/divide/shift unit.
// Multiplier pipeline depth and divider iteration count.

`ifndef BOA_SETTINGS_SVH
`define BOA_SETTINGS_SVH

// Number of multiplier pipeline stages.
// Legal values are 2 through 4.
`define BOA_MUL_STAGES 3

// Divider iterations, one quotient bit each.
`define BOA_DIV_STEPS 32

`endif

// File: logic/boa_div_iter.sv
// Iterative restoring divider, one quotient bit per cycle.
// Operands are made positive on start and signs are restored at the end.
// Zero divisor and signed overflow follow the RV32M results.

`include "boa_settings.svh"

module boa_div_iter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  boa_mdu_pkg::div_op_t   in,
    output logic                   busy,
    output boa_mdu_pkg::mdu_rsp_t  out,
    output logic                   done,
    input  logic                   ack
);

    localparam int step_w = $clog2(`BOA_DIV_STEPS);

    boa_mdu_pkg::div_state_e state;
    logic [step_w-1:0]       step;

    // Working registers.
    boa_isa_pkg::word_t      quo;
    boa_isa_pkg::word_t      part_rem;
    boa_isa_pkg::word_t      dvs;
    boa_isa_pkg::reg_idx_t   rd;
    logic                    sel_rem;
    logic                    neg_q;
    logic                    neg_r;
    logic                    div_zero;
    logic                    ovf;

    // Sign of each operand when signed.
    logic                    sign_l;
    logic                    sign_r;
    // One restoring step.
    logic [32:0]             rem_shift;
    logic [32:0]             rem_diff;
    // Results with signs restored.
    boa_isa_pkg::word_t      fix_quo;
    boa_isa_pkg::word_t      fix_rem;

    assign sign_l    = ~in.u & in.lhs[31];
    assign sign_r    = ~in.u & in.rhs[31];

    assign rem_shift = {part_rem, quo[31]};
    assign rem_diff  = rem_shift - {1'b0, dvs};

    // Quotient is all ones on a zero divisor.
    assign fix_quo = div_zero ? '1 :
                     ovf      ? 32'h8000_0000 :
                     neg_q    ? -quo : quo;
    // Zero divisor leaves |lhs| here, so the dividend comes back.
    assign fix_rem = ovf   ? '0 :
                     neg_r ? -part_rem : part_rem;

    // Control FSM.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= boa_mdu_pkg::IDLE;
            step  <= '0;
        end else begin
            case (state)
                boa_mdu_pkg::IDLE: begin
                    if (start) begin
                        state <= boa_mdu_pkg::RUN;
                        step  <= '0;
                    end
                end
                boa_mdu_pkg::RUN: begin
                    step <= step + 1'b1;
                    if (step == step_w'(`BOA_DIV_STEPS - 1)) begin
                        state <= boa_mdu_pkg::FIX;
                    end
                end
                boa_mdu_pkg::FIX: begin
                    state <= boa_mdu_pkg::DONE;
                end
                default: begin
                    // Hold result until the controller takes it.
                    if (ack) begin
                        state <= boa_mdu_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // Datapath.
    always_ff @(posedge clk) begin
        if (state == boa_mdu_pkg::IDLE && start) begin
            quo      <= sign_l ? -in.lhs : in.lhs;
            dvs      <= sign_r ? -in.rhs : in.rhs;
            part_rem <= '0;
            rd       <= in.rd;
            sel_rem  <= in.rem;
            neg_q    <= sign_l ^ sign_r;
            neg_r    <= sign_l;
            div_zero <= in.rhs == '0;
            ovf      <= ~in.u && in.lhs == 32'h8000_0000 && in.rhs == '1;
        end else if (state == boa_mdu_pkg::RUN) begin
            // Subtract when the shifted remainder covers the divisor.
            if (!rem_diff[32]) begin
                part_rem <= rem_diff[31:0];
                quo      <= {quo[30:0], 1'b1};
            end else begin
                part_rem <= rem_shift[31:0];
                quo      <= {quo[30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == boa_mdu_pkg::FIX) begin
            out.rd     <= rd;
            out.result <= sel_rem ? fix_rem : fix_quo;
        end
    end

    assign busy = state != boa_mdu_pkg::IDLE;
    assign done = state == boa_mdu_pkg::DONE;

endmodule

// File: logic/boa_isa_pkg.sv
// Instruction-level types of the RV32 core.
// Data word, register index and the multiply/divide/shift opcodes.

package boa_isa_pkg;

    // One operand or result word.
    typedef logic [31:0] word_t;

    // Destination register index.
    typedef logic [4:0] reg_idx_t;

    // Operations handled by the execution unit.
    typedef enum logic [3:0] {
        // Multiplies.
        MUL    = 4'd0,
        MULH   = 4'd1,
        MULHSU = 4'd2,
        MULHU  = 4'd3,
        // Divides and remainders.
        DIV    = 4'd4,
        DIVU   = 4'd5,
        REM    = 4'd6,
        REMU   = 4'd7,
        // Shifts, amount in rhs[4:0].
        SLL    = 4'd8,
        SRL    = 4'd9,
        SRA    = 4'd10
    } mdu_op_e;

endpackage

// File: logic/boa_mdu.sv
// Multiply/divide/shift execution unit, top level.
// Issue controller with a pipelined multiplier and an iterative divider.

module boa_mdu (
    input  logic                   clk,
    input  logic                   reset,
    input  boa_mdu_pkg::mdu_req_t  req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output boa_mdu_pkg::mdu_rsp_t  rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready
);

    // Controller to multiplier.
    boa_mdu_pkg::mul_op_t  mul_in;
    logic                  mul_in_valid;
    logic                  mul_advance;
    boa_mdu_pkg::mdu_rsp_t mul_out;
    logic                  mul_out_valid;

    // Controller to divider.
    boa_mdu_pkg::div_op_t  div_in;
    logic                  div_start;
    logic                  div_busy;
    boa_mdu_pkg::mdu_rsp_t div_out;
    logic                  div_done;
    logic                  div_ack;

    boa_mdu_ctrl i_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .mul_in        (mul_in),
        .mul_in_valid  (mul_in_valid),
        .mul_advance   (mul_advance),
        .mul_out       (mul_out),
        .mul_out_valid (mul_out_valid),
        .div_in        (div_in),
        .div_start     (div_start),
        .div_busy      (div_busy),
        .div_out       (div_out),
        .div_done      (div_done),
        .div_ack       (div_ack)
    );

    boa_mul_pipe i_mul (
        .clk       (clk),
        .reset     (reset),
        .advance   (mul_advance),
        .in        (mul_in),
        .in_valid  (mul_in_valid),
        .out       (mul_out),
        .out_valid (mul_out_valid)
    );

    boa_div_iter i_div (
        .clk   (clk),
        .reset (reset),
        .start (div_start),
        .in    (div_in),
        .busy  (div_busy),
        .out   (div_out),
        .done  (div_done),
        .ack   (div_ack)
    );

endmodule

// File: logic/boa_mdu_ctrl.sv
// Issue controller of the multiply/divide/shift unit.
// Decodes the opcode, routes work, computes shifts, counts multiplies
// in flight and owns the single response register.

`include "boa_settings.svh"

module boa_mdu_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  boa_mdu_pkg::mdu_req_t  req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output boa_mdu_pkg::mdu_rsp_t  rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output boa_mdu_pkg::mul_op_t   mul_in,
    output logic                   mul_in_valid,
    output logic                   mul_advance,
    input  boa_mdu_pkg::mdu_rsp_t  mul_out,
    input  logic                   mul_out_valid,
    output boa_mdu_pkg::div_op_t   div_in,
    output logic                   div_start,
    input  logic                   div_busy,
    input  boa_mdu_pkg::mdu_rsp_t  div_out,
    input  logic                   div_done,
    output logic                   div_ack
);

    localparam int cnt_w = $clog2(`BOA_MUL_STAGES + 1);

    logic                  is_mul;
    logic                  is_div;
    boa_isa_pkg::word_t    shift_res;
    logic                  rsp_free;
    logic                  req_fire;
    logic                  mul_take;
    logic                  shift_fire;
    logic [cnt_w-1:0]      mul_count;
    logic                  rsp_load;
    boa_mdu_pkg::mdu_rsp_t rsp_next;

    // Opcode decode and shifter.
    always_comb begin
        is_mul        = 1'b0;
        is_div        = 1'b0;
        shift_res     = '0;
        mul_in.u_lhs  = 1'b0;
        mul_in.u_rhs  = 1'b0;
        mul_in.high   = 1'b1;
        case (req.op)
            boa_isa_pkg::MUL: begin
                is_mul      = 1'b1;
                mul_in.high = 1'b0;
            end
            boa_isa_pkg::MULH: is_mul = 1'b1;
            boa_isa_pkg::MULHSU: begin
                is_mul       = 1'b1;
                mul_in.u_rhs = 1'b1;
            end
            boa_isa_pkg::MULHU: begin
                is_mul       = 1'b1;
                mul_in.u_lhs = 1'b1;
                mul_in.u_rhs = 1'b1;
            end
            boa_isa_pkg::DIV, boa_isa_pkg::DIVU,
            boa_isa_pkg::REM, boa_isa_pkg::REMU: is_div = 1'b1;
            boa_isa_pkg::SLL: shift_res = req.lhs << req.rhs[4:0];
            boa_isa_pkg::SRL: shift_res = req.lhs >> req.rhs[4:0];
            boa_isa_pkg::SRA: shift_res = $signed(req.lhs) >>> req.rhs[4:0];
            // Unknown encodings retire as a zero result.
            default: shift_res = '0;
        endcase
    end

    assign mul_in.lhs = req.lhs;
    assign mul_in.rhs = req.rhs;
    assign mul_in.rd  = req.rd;

    assign div_in.lhs = req.lhs;
    assign div_in.rhs = req.rhs;
    assign div_in.u   = req.op == boa_isa_pkg::DIVU || req.op == boa_isa_pkg::REMU;
    assign div_in.rem = req.op == boa_isa_pkg::REM || req.op == boa_isa_pkg::REMU;
    assign div_in.rd  = req.rd;

    // Response register empty or draining this cycle.
    assign rsp_free    = ~rsp_valid | rsp_ready;
    assign mul_advance = rsp_free;

    // Issue rules keep results in acceptance order.
    assign req_ready = is_mul ? ~div_busy & mul_advance
                              : ~div_busy & (mul_count == '0) & rsp_free;
    assign req_fire  = req_valid & req_ready;

    assign mul_in_valid = req_fire & is_mul;
    assign div_start    = req_fire & is_div;
    assign shift_fire   = req_fire & ~is_mul & ~is_div;

    // Sources never finish together.
    assign mul_take = mul_out_valid & mul_advance;
    assign div_ack  = div_done & rsp_free & ~mul_take;

    // Multiplies in flight.
    always_ff @(posedge clk) begin
        if (reset) begin
            mul_count <= '0;
        end else if (mul_in_valid && !mul_take) begin
            mul_count <= mul_count + 1'b1;
        end else if (!mul_in_valid && mul_take) begin
            mul_count <= mul_count - 1'b1;
        end
    end

    // Response source select.
    always_comb begin
        rsp_load        = 1'b1;
        rsp_next.rd     = req.rd;
        rsp_next.result = shift_res;
        if (mul_take) begin
            rsp_next = mul_out;
        end else if (div_ack) begin
            rsp_next = div_out;
        end else if (!shift_fire) begin
            rsp_load = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (rsp_load) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load) begin
            rsp <= rsp_next;
        end
    end

endmodule

// File: logic/boa_mdu_pkg.sv
// Internal types of the multiply/divide/shift unit.
// Request and response payloads, multiplier and divider inputs,
// multiplier stage contents and divider states.

package boa_mdu_pkg;

    // Request as seen on the input channel.
    typedef struct packed {
        boa_isa_pkg::mdu_op_e  op;
        boa_isa_pkg::word_t    lhs;
        boa_isa_pkg::word_t    rhs;
        boa_isa_pkg::reg_idx_t rd;
    } mdu_req_t;

    // Result tagged with its destination.
    typedef struct packed {
        boa_isa_pkg::reg_idx_t rd;
        boa_isa_pkg::word_t    result;
    } mdu_rsp_t;

    // Multiplier input.
    typedef struct packed {
        boa_isa_pkg::word_t    lhs;
        boa_isa_pkg::word_t    rhs;
        // Side is zero-extended.
        logic                  u_lhs;
        logic                  u_rhs;
        // Return upper half of product.
        logic                  high;
        boa_isa_pkg::reg_idx_t rd;
    } mul_op_t;

    // Divider input.
    typedef struct packed {
        boa_isa_pkg::word_t    lhs;
        boa_isa_pkg::word_t    rhs;
        logic                  u;
        // Return remainder instead of quotient.
        logic                  rem;
        boa_isa_pkg::reg_idx_t rd;
    } div_op_t;

    // Contents of one multiplier pipeline register.
    typedef struct packed {
        logic [63:0]           lhs;
        logic [63:0]           rhs;
        // Partial products summed so far.
        logic [63:0]           sum;
        logic                  high;
        boa_isa_pkg::reg_idx_t rd;
    } mul_stage_t;

    // Divider FSM states.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        FIX  = 2'd2,
        DONE = 2'd3
    } div_state_e;

endpackage

// File: logic/boa_mul_pipe.sv
// Pipelined multiplier.
// Sign or zero extends both operands to 64 bits and adds one
// shifted partial product per stage. The final add is combinational
// and feeds the response register, which acts as the last stage.

`include "boa_settings.svh"

module boa_mul_pipe #(
    parameter int stages = `BOA_MUL_STAGES
) (
    input  logic                   clk,
    input  logic                   reset,
    // Pipeline moves only while high.
    input  logic                   advance,
    input  boa_mdu_pkg::mul_op_t   in,
    input  logic                   in_valid,
    output boa_mdu_pkg::mdu_rsp_t  out,
    output logic                   out_valid
);

    // Bits of rhs consumed per stage.
    localparam int slice_w = (64 + stages - 1) / stages;

    typedef logic [slice_w-1:0] slice_t;

    // Partial product of one rhs slice, moved to its weight.
    function automatic logic [63:0] part_prod(input logic [63:0] a, input logic [63:0] b,
                                              input int k);
        slice_t      slice;
        logic [63:0] prod;
        slice = slice_t'(b >> (k * slice_w));
        prod  = a * slice;
        return prod << (k * slice_w);
    endfunction

    // Registered stages; the last stage is outside this module.
    boa_mdu_pkg::mul_stage_t st [stages-1];
    logic [stages-2:0]       vld;

    // Entry stage computed from the raw input.
    boa_mdu_pkg::mul_stage_t first;
    // Full 64-bit product at the pipeline exit.
    logic [63:0]             full;

    always_comb begin
        first.lhs  = {{32{~in.u_lhs & in.lhs[31]}}, in.lhs};
        first.rhs  = {{32{~in.u_rhs & in.rhs[31]}}, in.rhs};
        first.sum  = part_prod(first.lhs, first.rhs, 0);
        first.high = in.high;
        first.rd   = in.rd;
    end

    // Valid bits travel with the data.
    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else if (advance) begin
            vld[0] <= in_valid;
            for (int i = 1; i < stages - 1; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    // Payload moves on advance.
    always_ff @(posedge clk) begin
        if (advance) begin
            st[0] <= first;
            for (int i = 1; i < stages - 1; i++) begin
                st[i]     <= st[i-1];
                st[i].sum <= st[i-1].sum + part_prod(st[i-1].lhs, st[i-1].rhs, i);
            end
        end
    end

    // Last slice, then pick the word.
    assign full       = st[stages-2].sum +
                        part_prod(st[stages-2].lhs, st[stages-2].rhs, stages - 1);
    assign out.rd     = st[stages-2].rd;
    assign out.result = st[stages-2].high ? full[63:32] : full[31:0];
    assign out_valid  = vld[stages-2];

endmodule
